// ==== audio_pkg.sv ====
// ----------------------------------------------------------
// audio loopback package
// shared sample, slot and volume types and handshake states
// ----------------------------------------------------------

package audio_pkg;

  // ----------------------------------------------------------
  // frame geometry
  // ----------------------------------------------------------
  localparam int SAMPLE_W = 24;  // bits per audio sample
  localparam int SLOT_W   = 32;  // sclk periods per channel slot

  // signed pcm sample, MSB first on the wire
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // bit position inside one lrck slot
  typedef logic [$clog2(SLOT_W)-1:0] slot_pos_t;

  // ----------------------------------------------------------
  // volume control
  // ----------------------------------------------------------
  typedef logic [1:0] volume_t;  // {sw_1, sw_0}

  localparam volume_t VOL_FULL = 2'd3;  // no attenuation

  // ----------------------------------------------------------
  // four-phase source side
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    HS_IDLE,      // nothing offered
    HS_REQ,       // req high, waiting for ack
    HS_ACK_LOW    // req dropped, waiting for ack to fall
  } hs_state_t;

endpackage

// ==== sample_if.sv ====
// ----------------------------------------------------------
// sample channel between pipeline stages
// four-phase req/ack carrying one signed sample
// ----------------------------------------------------------
`timescale 1ns/10ps

interface sample_if import audio_pkg::*; ();

  logic    req;    // source offers data/right
  logic    ack;    // sink has taken them
  sample_t data;   // audio payload
  logic    right;  // high for the right channel

  // producing stage
  modport source (
    output req,
    output data,
    output right,
    input  ack
  );

  // consuming stage
  modport sink (
    input  req,
    input  data,
    input  right,
    output ack
  );

endinterface

// ==== i2s_timing_if.sv ====
// ----------------------------------------------------------
// i2s timing bundle
// sclk edge strobes, word select and bit position in slot
// ----------------------------------------------------------
`timescale 1ns/10ps

interface i2s_timing_if import audio_pkg::*; ();

  logic      sclk_rise;  // one clk after sclk goes high
  logic      sclk_fall;  // one clk after sclk goes low
  logic      lrck;       // 0 left slot, 1 right slot
  slot_pos_t bit_pos;    // current sclk period in slot

  modport source (
    output sclk_rise,
    output sclk_fall,
    output lrck,
    output bit_pos
  );

  modport sink (
    input sclk_rise,
    input sclk_fall,
    input lrck,
    input bit_pos
  );

endinterface

// ==== i2s_clock_gen.sv ====
// ----------------------------------------------------------
// i2s clock generator
// divides clk into sclk/lrck and tracks the slot bit position
// ----------------------------------------------------------
`timescale 1ns/10ps

module i2s_clock_gen import audio_pkg::*; #(
  parameter int SCLK_DIV = 4  // clk cycles per sclk, even and >= 4
) (
  input  logic               clk,
  input  logic               rst_n,
  output logic               sclk,
  output logic               lrck,
  i2s_timing_if.source       timing
);

  localparam int HALF_DIV = SCLK_DIV / 2;
  localparam int CNT_W    = (HALF_DIV > 1) ? $clog2(HALF_DIV) : 1;

  logic [CNT_W-1:0] div_cnt;  // clk cycles within one sclk phase
  logic             sclk_q;
  logic             lrck_q;
  logic             rise_q;
  logic             fall_q;
  slot_pos_t        pos_q;

  // ----------------------------------------------------------
  // sclk divider and slot counter
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
      sclk_q  <= 1'b0;
      lrck_q  <= 1'b0;
      rise_q  <= 1'b0;
      fall_q  <= 1'b0;
      pos_q   <= '0;
    end else begin
      rise_q <= 1'b0;
      fall_q <= 1'b0;
      if (div_cnt == CNT_W'(HALF_DIV - 1)) begin
        div_cnt <= '0;
        sclk_q  <= ~sclk_q;
        rise_q  <= ~sclk_q;  // going high
        fall_q  <= sclk_q;   // going low
        if (sclk_q) begin
          // new bit period starts on the falling edge
          if (pos_q == slot_pos_t'(SLOT_W - 1)) begin
            pos_q  <= '0;
            lrck_q <= ~lrck_q;  // next channel slot
          end else begin
            pos_q <= pos_q + 1'b1;
          end
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  assign sclk             = sclk_q;
  assign lrck             = lrck_q;
  assign timing.sclk_rise = rise_q;
  assign timing.sclk_fall = fall_q;
  assign timing.lrck      = lrck_q;
  assign timing.bit_pos   = pos_q;

  // a rise is always followed half a period later by a fall, never with it
  assert property (@(posedge clk) disable iff (!rst_n)
    rise_q |-> !fall_q ##HALF_DIV fall_q);

endmodule

// ==== i2s_receiver.sv ====
// ----------------------------------------------------------
// i2s receiver
// deserializes sdin and hands samples on with req/ack
// ----------------------------------------------------------
`timescale 1ns/10ps

module i2s_receiver import audio_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         sdin,
  i2s_timing_if.sink   timing,
  sample_if.source     out
);

  logic [SAMPLE_W-1:0] shift_q;     // incoming bits, MSB first
  logic                sample_done; // last sample bit just shifted in
  logic                in_window;   // bit_pos 1..SAMPLE_W
  hs_state_t           state;
  logic                req_q;
  sample_t             data_q;
  logic                right_q;

  assign in_window = (timing.bit_pos >= slot_pos_t'(1)) &&
                     (timing.bit_pos <= slot_pos_t'(SAMPLE_W));

  // ----------------------------------------------------------
  // deserializer
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (timing.sclk_rise && in_window) begin
      shift_q <= {shift_q[SAMPLE_W-2:0], sdin};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sample_done <= 1'b0;
    end else begin
      sample_done <= timing.sclk_rise &&
                     (timing.bit_pos == slot_pos_t'(SAMPLE_W));
    end
  end

  // payload held stable while req is up
  always_ff @(posedge clk) begin
    if (sample_done && state == HS_IDLE) begin
      data_q  <= sample_t'(shift_q);
      right_q <= timing.lrck;  // still inside the same slot
    end
  end

  // ----------------------------------------------------------
  // four-phase source
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= HS_IDLE;
      req_q <= 1'b0;
    end else begin
      case (state)
        HS_IDLE: begin
          if (sample_done) begin
            req_q <= 1'b1;
            state <= HS_REQ;
          end
        end
        HS_REQ: begin
          if (out.ack) begin
            req_q <= 1'b0;
            state <= HS_ACK_LOW;
          end
        end
        HS_ACK_LOW: begin
          if (!out.ack) begin
            state <= HS_IDLE;  // ready for the next slot
          end
        end
        default: begin
          req_q <= 1'b0;
          state <= HS_IDLE;
        end
      endcase
    end
  end

  assign out.req   = req_q;
  assign out.data  = data_q;
  assign out.right = right_q;

  // single buffer: downstream must finish within one slot
  assert property (@(posedge clk) disable iff (!rst_n)
    sample_done |-> state == HS_IDLE);

endmodule

// ==== volume_scaler.sv ====
// ----------------------------------------------------------
// volume stage
// switch synchronizer and arithmetic-shift attenuation
// ----------------------------------------------------------
`timescale 1ns/10ps

module volume_scaler import audio_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sw_0,
  input  logic       sw_1,
  sample_if.sink     in,
  sample_if.source   out
);

  logic [1:0] sw_meta;   // first sync stage
  volume_t    volume;    // second stage, sw_1 is msb
  hs_state_t  state;
  logic       in_ack_q;
  logic       out_req_q;
  sample_t    data_q;
  logic       right_q;
  logic       take;      // new upstream sample this cycle

  // ----------------------------------------------------------
  // switch synchronizer
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sw_meta <= '0;
      volume  <= '0;
    end else begin
      sw_meta <= {sw_1, sw_0};
      volume  <= volume_t'(sw_meta);
    end
  end

  // only in idle, and not while still acking the previous one
  assign take = (state == HS_IDLE) && in.req && !in_ack_q;

  // attenuated payload, 0..3 bits of shift
  always_ff @(posedge clk) begin
    if (take) begin
      data_q  <= in.data >>> (VOL_FULL - volume);
      right_q <= in.right;
    end
  end

  // ----------------------------------------------------------
  // upstream sink / downstream source
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= HS_IDLE;
      in_ack_q  <= 1'b0;
      out_req_q <= 1'b0;
    end else begin
      if (in_ack_q && !in.req) begin
        in_ack_q <= 1'b0;  // phase 4 upstream
      end
      case (state)
        HS_IDLE: begin
          if (take) begin
            out_req_q <= 1'b1;
            state     <= HS_REQ;
          end
        end
        HS_REQ: begin
          if (out.ack) begin
            out_req_q <= 1'b0;
            state     <= HS_ACK_LOW;
          end
        end
        HS_ACK_LOW: begin
          if (!out.ack) begin
            in_ack_q <= 1'b1;  // downstream done, release upstream
            state    <= HS_IDLE;
          end
        end
        default: begin
          out_req_q <= 1'b0;
          state     <= HS_IDLE;
        end
      endcase
    end
  end

  assign in.ack    = in_ack_q;
  assign out.req   = out_req_q;
  assign out.data  = data_q;
  assign out.right = right_q;

endmodule

// ==== i2s_transmitter.sv ====
// ----------------------------------------------------------
// i2s transmitter
// per-channel sample buffers serialized onto sdout
// ----------------------------------------------------------
`timescale 1ns/10ps

module i2s_transmitter import audio_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  output logic         sdout,
  i2s_timing_if.sink   timing,
  sample_if.sink       in
);

  sample_t             buf_left;   // latest left sample
  sample_t             buf_right;  // latest right sample
  logic [SAMPLE_W-1:0] shift_q;
  logic                ack_q;
  logic                sdout_q;
  logic                in_window;

  assign in_window = (timing.bit_pos >= slot_pos_t'(1)) &&
                     (timing.bit_pos <= slot_pos_t'(SAMPLE_W));

  // ----------------------------------------------------------
  // sample buffers acked one cycle after req
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      buf_left  <= '0;
      buf_right <= '0;
      ack_q     <= 1'b0;
    end else begin
      ack_q <= in.req;  // follows req both ways
      if (in.req && !ack_q) begin
        if (in.right) begin
          buf_right <= in.data;
        end else begin
          buf_left <= in.data;
        end
      end
    end
  end

  assign in.ack = ack_q;

  // ----------------------------------------------------------
  // serializer changing on sclk falling edges
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shift_q <= '0;
      sdout_q <= 1'b0;
    end else if (timing.sclk_fall) begin
      if (timing.bit_pos == '0) begin
        // lrck already switched, pick this slot's channel
        shift_q <= timing.lrck ? buf_right : buf_left;
        sdout_q <= 1'b0;  // one-bit delay after lrck edge
      end else if (in_window) begin
        sdout_q <= shift_q[SAMPLE_W-1];
        shift_q <= {shift_q[SAMPLE_W-2:0], 1'b0};
      end else begin
        sdout_q <= 1'b0;  // padding bits
      end
    end
  end

  assign sdout = sdout_q;

  // upstream must have seen ack low before raising a new req
  assert property (@(posedge clk) disable iff (!rst_n)
    $rose(in.req) |-> !$past(ack_q));

endmodule

// ==== audio_loopback_top.sv ====
// ----------------------------------------------------------
// audio loopback top level
// i2s adc in, switch-controlled volume, i2s dac out
// ----------------------------------------------------------
`timescale 1ns/10ps

module audio_loopback_top #(
  parameter int SCLK_DIV = 4  // clk cycles per sclk period
) (
  input  logic clk,
  input  logic rst_n,
  input  logic sdin,   // adc serial data
  input  logic sw_0,   // volume lsb
  input  logic sw_1,   // volume msb
  output logic sclk,   // shared bit clock
  output logic lrck,   // shared word clock
  output logic sdout   // dac serial data
);

  i2s_timing_if timing ();
  sample_if     rx_to_vol ();
  sample_if     vol_to_tx ();

  // ----------------------------------------------------------
  // bit and word clocks
  // ----------------------------------------------------------
  i2s_clock_gen #(
    .SCLK_DIV (SCLK_DIV)
  ) u_clock_gen (
    .clk    (clk),
    .rst_n  (rst_n),
    .sclk   (sclk),
    .lrck   (lrck),
    .timing (timing.source)
  );

  // ----------------------------------------------------------
  // adc -> volume -> dac
  // ----------------------------------------------------------
  i2s_receiver u_receiver (
    .clk    (clk),
    .rst_n  (rst_n),
    .sdin   (sdin),
    .timing (timing.sink),
    .out    (rx_to_vol.source)
  );

  volume_scaler u_volume (
    .clk   (clk),
    .rst_n (rst_n),
    .sw_0  (sw_0),
    .sw_1  (sw_1),
    .in    (rx_to_vol.sink),
    .out   (vol_to_tx.source)
  );

  i2s_transmitter u_transmitter (
    .clk    (clk),
    .rst_n  (rst_n),
    .sdout  (sdout),
    .timing (timing.sink),
    .in     (vol_to_tx.sink)
  );

endmodule

// ==== tb_audio_loopback.sv ====
// ------------------------------------------------------------
// audio loopback testbench
// i2s adc model, dac capture and directed loopback checks
// ------------------------------------------------------------
`timescale 1ns/10ps

module tb_audio_loopback import audio_pkg::*; ();

  localparam int SCLK_DIV       = 4;
  localparam int CLK_NS         = 4;
  localparam int FRAME_CYCLES   = 2 * SLOT_W * SCLK_DIV;     // 256 clk per frame
  localparam int TIMEOUT_CYCLES = 70 * FRAME_CYCLES + 2080;  // ~20k, tests need ~40 frames
  localparam int FRAMES         = 128;                       // frame slots in the records

  logic clk;
  logic rst_n;
  logic sdin;
  logic sw_0;
  logic sw_1;
  logic sclk;
  logic lrck;
  logic sdout;

  sample_t     adc_left  [FRAMES];  // what the adc model sends per frame
  sample_t     adc_right [FRAMES];
  logic [31:0] cap_left  [FRAMES];  // whole slot words seen on sdout
  logic [31:0] cap_right [FRAMES];
  int          in_frame   = 0;      // frame the adc model is in
  int          cap_frames = 0;      // frames fully captured
  int          cycles     = 0;
  int          seed       = 32'h4e29;

  audio_loopback_top #(
    .SCLK_DIV (SCLK_DIV)
  ) dut (
    .clk   (clk),
    .rst_n (rst_n),
    .sdin  (sdin),
    .sw_0  (sw_0),
    .sw_1  (sw_1),
    .sclk  (sclk),
    .lrck  (lrck),
    .sdout (sdout)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: tests did not finish within %0d clk cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $fatal(1, "simulation timed out");
    end
  end

  // ------------------------------------------------------------
  // i2s models, both track the slot from sampled sclk/lrck
  // ------------------------------------------------------------
  task automatic adc_model;
    logic    sclk_d;
    logic    lrck_d;
    int      pos;
    int      frame;
    sample_t s;
    sclk_d = 1'b0;
    lrck_d = 1'b0;
    pos    = 0;
    frame  = 0;
    sdin   = 1'b0;
    forever begin
      @(posedge clk);
      if (!sclk && sclk_d) begin  // sclk fell on the last edge
        if (lrck != lrck_d) begin
          pos = 0;                 // new slot
          if (!lrck) frame++;      // left slot opens a frame
        end else begin
          pos++;
        end
        lrck_d   = lrck;
        in_frame = frame;
        s = (frame >= FRAMES) ? '0 : (lrck ? adc_right[frame] : adc_left[frame]);
        sdin <= (pos >= 1 && pos <= SAMPLE_W) ? s[SAMPLE_W-pos] : 1'b0;  // MSB at pos 1
      end
      sclk_d = sclk;
    end
  endtask

  task automatic capture_model;
    logic        sclk_d;
    logic        lrck_d;
    int          pos;
    int          frame;
    logic [31:0] word;
    sclk_d = 1'b0;
    lrck_d = 1'b0;
    pos    = 0;
    frame  = 0;
    word   = '0;
    forever begin
      @(posedge clk);
      if (!sclk && sclk_d) begin
        if (lrck != lrck_d) begin
          pos = 0;
          if (!lrck) frame++;
        end else begin
          pos++;
        end
        lrck_d = lrck;
      end
      if (sclk && !sclk_d) begin  // sdout stable mid period
        word = {word[30:0], sdout};
        if (pos == SLOT_W - 1 && frame < FRAMES) begin
          if (lrck) begin
            cap_right[frame] = word;
            cap_frames       = frame + 1;  // right slot closes the frame
          end else begin
            cap_left[frame] = word;
          end
        end
      end
      sclk_d = sclk;
    end
  endtask

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "value check %s mismatched", name);
    end
  endtask

  // zero at pos 0, sample at 1..24, zero padding after
  function automatic logic [31:0] slot_word(input sample_t s);
    return {1'b0, s, {(SLOT_W - SAMPLE_W - 1){1'b0}}};
  endfunction

  // attenuation by 3 minus the switch value, sign kept
  function automatic sample_t scale(input sample_t s, input volume_t vol);
    int sh;
    sh = 3 - int'(vol);
    return s >>> sh;
  endfunction

  task automatic set_volume(input volume_t vol);
    @(posedge clk);
    sw_1 <= vol[1];
    sw_0 <= vol[0];
  endtask

  // mode 0 random both, mode 1 left positive and right negative
  task automatic fill_frames(input int f0, input int n, input int mode);
    logic [31:0] r;
    for (int f = f0; f < f0 + n; f++) begin
      r = $random(seed);
      adc_left[f] = (mode == 1) ? {1'b0, r[22:0]} : r[23:0];
      r = $random(seed);
      adc_right[f] = (mode == 1) ? {1'b1, r[22:0]} : r[23:0];
    end
  endtask

  // frame f input must come back in frame f+1
  task automatic send_and_check(input string name, input volume_t vol, input int n,
                                input int mode);
    int f0;
    set_volume(vol);
    f0 = in_frame + 3;  // skip a frame after the switch change
    fill_frames(f0, n, mode);
    wait (cap_frames > f0 + n);
    for (int f = f0; f < f0 + n; f++) begin
      check_value($sformatf("%s left frame %0d", name, f),
                  slot_word(scale(adc_left[f], vol)), cap_left[f+1]);
      check_value($sformatf("%s right frame %0d", name, f),
                  slot_word(scale(adc_right[f], vol)), cap_right[f+1]);
    end
  endtask

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------
  task automatic test_reset_state;
    wait (cap_frames >= 2);
    for (int f = 0; f < 2; f++) begin
      check_value($sformatf("reset_state left frame %0d", f), '0, cap_left[f]);
      check_value($sformatf("reset_state right frame %0d", f), '0, cap_right[f]);
    end
  endtask

  task automatic test_frame_timing;
    time t0;
    time t1;
    @(posedge sclk);
    t0 = $time;
    @(posedge sclk);
    t1 = $time;
    check_value("sclk_period", SCLK_DIV, 32'((t1 - t0) / CLK_NS));
    @(lrck);
    t0 = $time;
    @(lrck);
    t1 = $time;
    check_value("lrck_slot_length", SLOT_W * SCLK_DIV, 32'((t1 - t0) / CLK_NS));
  endtask

  task automatic test_full_volume;
    send_and_check("full_volume", 2'd3, 4, 0);
  endtask

  task automatic test_channel_order;
    send_and_check("channel_order", 2'd3, 3, 1);
  endtask

  task automatic test_attenuation;
    for (int v = 0; v < 3; v++) begin
      send_and_check($sformatf("attenuation vol %0d", v), volume_t'(v), 3, 1);
    end
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    for (int f = 0; f < FRAMES; f++) begin
      adc_left[f]  = '0;
      adc_right[f] = '0;
      cap_left[f]  = '0;
      cap_right[f] = '0;
    end
    rst_n = 1'b0;
    sw_0  = 1'b1;  // full volume
    sw_1  = 1'b1;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_state();
    test_frame_timing();
    test_full_volume();
    test_channel_order();
    test_attenuation();
    $display("STATUS: PASS");
    $finish;
  end

  initial adc_model();
  initial capture_model();

endmodule

// ==== build.f ====
audio_pkg.sv
sample_if.sv
i2s_timing_if.sv
i2s_clock_gen.sv
i2s_receiver.sv
volume_scaler.sv
i2s_transmitter.sv
audio_loopback_top.sv
tb_audio_loopback.sv

// ==== Bender.yml ====
package:
  name: audio_loopback

sources:
  - audio_pkg.sv
  - sample_if.sv
  - i2s_timing_if.sv
  - i2s_clock_gen.sv
  - i2s_receiver.sv
  - volume_scaler.sv
  - i2s_transmitter.sv
  - audio_loopback_top.sv
  - target: simulation
    files:
      - tb_audio_loopback.sv
